// File: usb_pkg.sv
package usb_pkg;

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////

   // Host side address, bits 5 to 0 of a header
   typedef logic [5:0] reg_addr_t;

   localparam reg_addr_t gain_addr     = 6'd0;
   localparam reg_addr_t settings_addr = 6'd1;
   localparam reg_addr_t status_addr   = 6'd2;
   // Read only, starts a FIFO dump
   localparam reg_addr_t adcdata_addr  = 6'd3;
   localparam reg_addr_t echo_addr     = 6'd4;
   // Frequency snapshot, LSB first
   localparam reg_addr_t extfreq_addr0 = 6'd5;
   localparam reg_addr_t extfreq_addr1 = 6'd6;
   localparam reg_addr_t extfreq_addr2 = 6'd7;
   localparam reg_addr_t extfreq_addr3 = 6'd8;
   // Phase adjust, high byte carries bit 8 plus load/done
   localparam reg_addr_t phase_lo_addr = 6'd9;
   localparam reg_addr_t phase_hi_addr = 6'd10;

   // Widths of the capture board side
   localparam int freq_w  = 32;
   localparam int phase_w = 9;

   // 100 MHz at 115200 baud
   localparam int clks_per_bit_default = 868;

   //////////////////////////////////////////////////
   // Byte formats
   //////////////////////////////////////////////////

   // Header: bit 7 marks a command, bit 6 picks write
   typedef struct packed {
      logic      is_cmd;
      logic      is_write;
      reg_addr_t addr;
   } cmd_hdr_s;

   // Same received word, seen as data or as header
   typedef union packed {
      logic [7:0] data;
      cmd_hdr_s   hdr;
   } rx_byte_u;

   // Settings register, bit 7 down to bit 0
   typedef struct packed {
      logic src_internal;
      logic adc_clk_ext;
      logic trig_wait;
      logic pll_reset;
      logic arm;
      logic trig_high;
      logic hilow;
      logic sys_reset;
   } settings_s;

   // One register write, valid with the strobe
   typedef struct packed {
      reg_addr_t  addr;
      logic [7:0] data;
   } reg_wr_s;

   // Power-up register contents
   localparam logic [7:0] gain_rst     = 8'h00;
   localparam settings_s  settings_rst = '0;
   localparam logic [7:0] echo_rst     = 8'h00;

endpackage

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic              ftdi_clk,
   input  logic              reset,
   input  logic              rx_i,
   output logic              rx_valid_o,
   output usb_pkg::rx_byte_u rx_byte_o
);

   localparam int cnt_w = $clog2(CLKS_PER_BIT);
   // Bit centre and half-bit compare points
   localparam logic [cnt_w-1:0] last_cnt = cnt_w'(CLKS_PER_BIT - 1);
   localparam logic [cnt_w-1:0] half_cnt = cnt_w'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_e;

   rx_state_e        state;
   logic [1:0]       sync_q;
   logic             rx_s;
   logic [cnt_w-1:0] baud_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       shift_q;

   // Line after the two-flop synchronizer
   assign rx_s      = sync_q[1];
   assign rx_byte_o = shift_q;

   always_ff @(posedge ftdi_clk or posedge reset) begin
      if (reset) begin
         // Idle line is high
         sync_q     <= 2'b11;
         state      <= rx_idle;
         baud_cnt   <= '0;
         bit_cnt    <= '0;
         rx_valid_o <= 1'b0;
      end else begin
         sync_q     <= {sync_q[0], rx_i};
         rx_valid_o <= 1'b0;
         case (state)
            rx_idle: begin
               baud_cnt <= '0;
               // Falling start edge
               if (!rx_s) begin
                  state <= rx_start;
               end
            end
            rx_start: begin
               if (baud_cnt == half_cnt) begin
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  // Glitch, start bit gone high again
                  state    <= rx_s ? rx_idle : rx_data;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            rx_data: begin
               if (baud_cnt == last_cnt) begin
                  baud_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     state <= rx_stop;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            rx_stop: begin
               if (baud_cnt == last_cnt) begin
                  state      <= rx_idle;
                  // Framing error drops the byte
                  rx_valid_o <= rx_s;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // LSB arrives first, shift in from the top
   always_ff @(posedge ftdi_clk) begin
      if (state == rx_data && baud_cnt == last_cnt) begin
         shift_q <= {rx_s, shift_q[7:1]};
      end
   end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       ftdi_clk,
   input  logic       reset,
   input  logic       tx_valid_i,
   input  logic [7:0] tx_data_i,
   output logic       tx_ready_o,
   output logic       tx_o
);

   localparam int cnt_w = $clog2(CLKS_PER_BIT);
   localparam logic [cnt_w-1:0] last_cnt = cnt_w'(CLKS_PER_BIT - 1);

   // Stop, data, start; bit 0 drives the line
   logic [9:0]       shift_q;
   logic [cnt_w-1:0] baud_cnt;
   logic [3:0]       bit_cnt;
   logic             busy;

   assign tx_ready_o = ~busy;
   assign tx_o       = shift_q[0];

   always_ff @(posedge ftdi_clk or posedge reset) begin
      if (reset) begin
         shift_q  <= '1;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         busy     <= 1'b0;
      end else if (!busy) begin
         // Accept, line falls next cycle
         if (tx_valid_i) begin
            shift_q  <= {1'b1, tx_data_i, 1'b0};
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b1;
         end
      end else if (baud_cnt == last_cnt) begin
         baud_cnt <= '0;
         shift_q  <= {1'b1, shift_q[9:1]};
         // End of stop bit frees the slot
         if (bit_cnt == 4'd9) begin
            busy <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   // Idle transmitter leaves the line marking
   assert property (@(posedge ftdi_clk) disable iff (reset)
      tx_ready_o |-> tx_o);

endmodule

// File: cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
   input  logic                ftdi_clk,
   input  logic                reset,
   input  logic                rx_valid_i,
   input  usb_pkg::rx_byte_u   rx_byte_i,
   input  logic [7:0]          rd_data_i,
   input  logic                rd_hit_i,
   input  logic                tx_ready_i,
   input  logic                fifo_empty_i,
   input  logic [7:0]          fifo_data_i,
   output logic                reg_wr_valid_o,
   output usb_pkg::reg_wr_s    reg_wr_o,
   output logic                rd_strobe_o,
   output usb_pkg::reg_addr_t  rd_addr_o,
   output logic                tx_valid_o,
   output logic [7:0]          tx_data_o,
   output logic                fifo_rd_en_o
);

   typedef enum logic [2:0] {
      idle,
      wait_data,
      read_reply,
      dump_wait,
      dump_fetch,
      send
   } seq_state_e;

   seq_state_e         state;
   usb_pkg::reg_addr_t addr_q;
   logic               is_dump;

   // Address from the last header
   assign rd_addr_o = addr_q;
   // ADC data is the one address decoded here
   assign is_dump   = (addr_q == usb_pkg::adcdata_addr);

   //////////////////////////////////////////////////
   // Command FSM
   //////////////////////////////////////////////////

   always_ff @(posedge ftdi_clk or posedge reset) begin
      if (reset) begin
         state          <= idle;
         addr_q         <= '0;
         reg_wr_valid_o <= 1'b0;
         rd_strobe_o    <= 1'b0;
         tx_valid_o     <= 1'b0;
         fifo_rd_en_o   <= 1'b0;
      end else begin
         // Strobes last one cycle
         reg_wr_valid_o <= 1'b0;
         rd_strobe_o    <= 1'b0;
         fifo_rd_en_o   <= 1'b0;
         case (state)
            idle: begin
               // Bit 7 clear, byte ignored
               if (rx_valid_i && rx_byte_i.hdr.is_cmd) begin
                  addr_q <= rx_byte_i.hdr.addr;
                  if (rx_byte_i.hdr.is_write) begin
                     state <= wait_data;
                  end else begin
                     rd_strobe_o <= 1'b1;
                     state       <= read_reply;
                  end
               end
            end
            wait_data: begin
               if (rx_valid_i) begin
                  reg_wr_valid_o <= 1'b1;
                  state          <= idle;
               end
            end
            read_reply: begin
               // rd_data_i valid now, strobe is high
               if (is_dump) begin
                  state <= dump_wait;
               end else if (rd_hit_i) begin
                  tx_valid_o <= 1'b1;
                  state      <= send;
               end else begin
                  state <= idle;
               end
            end
            dump_wait: begin
               // Pop only with a free transmit slot
               if (tx_ready_i) begin
                  if (fifo_empty_i) begin
                     state <= idle;
                  end else begin
                     fifo_rd_en_o <= 1'b1;
                     state        <= dump_fetch;
                  end
               end
            end
            dump_fetch: begin
               // FIFO data lands one cycle after the pop
               if (!fifo_rd_en_o) begin
                  tx_valid_o <= 1'b1;
                  state      <= send;
               end
            end
            send: begin
               if (tx_ready_i) begin
                  tx_valid_o <= 1'b0;
                  state      <= is_dump ? dump_wait : idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Payload capture
   //////////////////////////////////////////////////

   always_ff @(posedge ftdi_clk) begin
      if (state == wait_data && rx_valid_i) begin
         reg_wr_o.addr <= addr_q;
         reg_wr_o.data <= rx_byte_i.data;
      end
      // Register reply or FIFO byte
      if (state == read_reply) begin
         tx_data_o <= rd_data_i;
      end else if (state == dump_fetch && !fifo_rd_en_o) begin
         tx_data_o <= fifo_data_i;
      end
   end

   // Pop follows a non-empty sample from the cycle before
   assert property (@(posedge ftdi_clk) disable iff (reset)
      $rose(fifo_rd_en_o) |-> !fifo_empty_i);

   // Byte held until the transmitter takes it
   assert property (@(posedge ftdi_clk) disable iff (reset)
      tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o));

endmodule

// File: config_regs.sv
`timescale 1ns/1ps

module config_regs (
   input  logic                         ftdi_clk,
   input  logic                         reset,
   input  logic                         reg_wr_valid_i,
   input  usb_pkg::reg_wr_s             reg_wr_i,
   input  logic                         rd_strobe_i,
   input  usb_pkg::reg_addr_t           rd_addr_i,
   input  logic [7:0]                   status_i,
   input  logic [usb_pkg::freq_w-1:0]   extclk_frequency_i,
   input  logic [usb_pkg::phase_w-1:0]  phase_i,
   input  logic                         phase_done_i,
   output logic [7:0]                   rd_data_o,
   output logic                         rd_hit_o,
   output logic [7:0]                   gain_o,
   output usb_pkg::settings_s           ctrl_o,
   output logic [usb_pkg::phase_w-1:0]  phase_o,
   output logic                         phase_ld_o
);

   logic [7:0]                  echo_q;
   logic [usb_pkg::phase_w-1:0] phase_in_q;
   logic                        phase_done_q;
   logic [usb_pkg::freq_w-1:0]  freq_snap;
   logic                        freq_lock;
   logic                        lock_req;

   //////////////////////////////////////////////////
   // Host writes
   //////////////////////////////////////////////////

   always_ff @(posedge ftdi_clk or posedge reset) begin
      if (reset) begin
         gain_o     <= usb_pkg::gain_rst;
         ctrl_o     <= usb_pkg::settings_rst;
         echo_q     <= usb_pkg::echo_rst;
         phase_o    <= '0;
         phase_ld_o <= 1'b0;
      end else begin
         phase_ld_o <= 1'b0;
         if (reg_wr_valid_i) begin
            case (reg_wr_i.addr)
               usb_pkg::gain_addr:     gain_o <= reg_wr_i.data;
               // Fields map bit for bit
               usb_pkg::settings_addr: ctrl_o <= usb_pkg::settings_s'(reg_wr_i.data);
               usb_pkg::echo_addr:     echo_q <= reg_wr_i.data;
               usb_pkg::phase_lo_addr: phase_o[7:0] <= reg_wr_i.data;
               usb_pkg::phase_hi_addr: begin
                  // Bit 0 is phase MSB, bit 1 starts the load
                  phase_o[usb_pkg::phase_w-1] <= reg_wr_i.data[0];
                  phase_ld_o                  <= reg_wr_i.data[1];
               end
               default: ;
            endcase
         end
      end
   end

   // Phase result from the shifter, cleared by a new load
   always_ff @(posedge ftdi_clk or posedge reset) begin
      if (reset) begin
         phase_in_q   <= '0;
         phase_done_q <= 1'b0;
      end else if (phase_ld_o) begin
         phase_in_q   <= '0;
         phase_done_q <= 1'b0;
      end else if (phase_done_i) begin
         phase_in_q   <= phase_i;
         phase_done_q <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Frequency snapshot
   //////////////////////////////////////////////////

   // Reads of the lower three bytes hold the count
   assign lock_req = rd_strobe_i && (rd_addr_i == usb_pkg::extfreq_addr0 ||
                                     rd_addr_i == usb_pkg::extfreq_addr1 ||
                                     rd_addr_i == usb_pkg::extfreq_addr2);

   // Any other read releases
   always_ff @(posedge ftdi_clk or posedge reset) begin
      if (reset) begin
         freq_lock <= 1'b0;
      end else if (rd_strobe_i) begin
         freq_lock <= lock_req;
      end
   end

   // Frozen already on the edge of the first locking read
   always_ff @(posedge ftdi_clk) begin
      if (!freq_lock && !lock_req) begin
         freq_snap <= extclk_frequency_i;
      end
   end

   // Read mux, no hit means no reply
   always_comb begin
      rd_data_o = '0;
      rd_hit_o  = 1'b1;
      case (rd_addr_i)
         usb_pkg::gain_addr:     rd_data_o = gain_o;
         usb_pkg::settings_addr: rd_data_o = ctrl_o;
         usb_pkg::status_addr:   rd_data_o = status_i;
         usb_pkg::echo_addr:     rd_data_o = echo_q;
         usb_pkg::extfreq_addr0: rd_data_o = freq_snap[7:0];
         usb_pkg::extfreq_addr1: rd_data_o = freq_snap[15:8];
         usb_pkg::extfreq_addr2: rd_data_o = freq_snap[23:16];
         usb_pkg::extfreq_addr3: rd_data_o = freq_snap[31:24];
         usb_pkg::phase_lo_addr: rd_data_o = phase_in_q[7:0];
         usb_pkg::phase_hi_addr: begin
            rd_data_o = {6'b0, phase_done_q, phase_in_q[usb_pkg::phase_w-1]};
         end
         default: rd_hit_o = 1'b0;
      endcase
   end

   // Writes arrive at most every other cycle
   assert property (@(posedge ftdi_clk) disable iff (reset)
      phase_ld_o |=> !phase_ld_o);

endmodule

// File: usb_interface.sv
`timescale 1ns/1ps

module usb_interface #(
   parameter int CLKS_PER_BIT = usb_pkg::clks_per_bit_default
) (
   input  logic                         ftdi_clk,
   input  logic                         reset,
   input  logic                         rx_i,
   input  logic [7:0]                   status_i,
   input  logic                         fifo_empty_i,
   input  logic [7:0]                   fifo_data_i,
   input  logic [usb_pkg::freq_w-1:0]   extclk_frequency_i,
   input  logic [usb_pkg::phase_w-1:0]  phase_i,
   input  logic                         phase_done_i,
   output logic                         tx_o,
   output logic [7:0]                   gain_o,
   output usb_pkg::settings_s           ctrl_o,
   output logic                         fifo_rd_en_o,
   output logic [usb_pkg::phase_w-1:0]  phase_o,
   output logic                         phase_ld_o
);

   // Receiver to sequencer
   logic               rx_valid;
   usb_pkg::rx_byte_u  rx_byte;
   // Sequencer to transmitter
   logic               tx_valid;
   logic [7:0]         tx_data;
   logic               tx_ready;
   // Sequencer to register file
   logic               reg_wr_valid;
   usb_pkg::reg_wr_s   reg_wr;
   logic               rd_strobe;
   usb_pkg::reg_addr_t rd_addr;
   logic [7:0]         rd_data;
   logic               rd_hit;

   //////////////////////////////////////////////////
   // Serial line
   //////////////////////////////////////////////////

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) rx_inst (
      .ftdi_clk   (ftdi_clk),
      .reset      (reset),
      .rx_i       (rx_i),
      .rx_valid_o (rx_valid),
      .rx_byte_o  (rx_byte)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) tx_inst (
      .ftdi_clk   (ftdi_clk),
      .reset      (reset),
      .tx_valid_i (tx_valid),
      .tx_data_i  (tx_data),
      .tx_ready_o (tx_ready),
      .tx_o       (tx_o)
   );

   //////////////////////////////////////////////////
   // Command and register blocks
   //////////////////////////////////////////////////

   cmd_sequencer seq_inst (
      .ftdi_clk       (ftdi_clk),
      .reset          (reset),
      .rx_valid_i     (rx_valid),
      .rx_byte_i      (rx_byte),
      .rd_data_i      (rd_data),
      .rd_hit_i       (rd_hit),
      .tx_ready_i     (tx_ready),
      .fifo_empty_i   (fifo_empty_i),
      .fifo_data_i    (fifo_data_i),
      .reg_wr_valid_o (reg_wr_valid),
      .reg_wr_o       (reg_wr),
      .rd_strobe_o    (rd_strobe),
      .rd_addr_o      (rd_addr),
      .tx_valid_o     (tx_valid),
      .tx_data_o      (tx_data),
      .fifo_rd_en_o   (fifo_rd_en_o)
   );

   config_regs regs_inst (
      .ftdi_clk           (ftdi_clk),
      .reset              (reset),
      .reg_wr_valid_i     (reg_wr_valid),
      .reg_wr_i           (reg_wr),
      .rd_strobe_i        (rd_strobe),
      .rd_addr_i          (rd_addr),
      .status_i           (status_i),
      .extclk_frequency_i (extclk_frequency_i),
      .phase_i            (phase_i),
      .phase_done_i       (phase_done_i),
      .rd_data_o          (rd_data),
      .rd_hit_o           (rd_hit),
      .gain_o             (gain_o),
      .ctrl_o             (ctrl_o),
      .phase_o            (phase_o),
      .phase_ld_o         (phase_ld_o)
   );

endmodule

// File: tb_host_tasks.svh
//////////////////////////////////////////////////
// Random numbers and checks
//////////////////////////////////////////////////

// LCG state, seeded once
logic [31:0] lcg_state = 32'd50;

// Upper bits, low bits of an LCG repeat quickly
function automatic logic [15:0] next_random();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return lcg_state[30:15];
endfunction

task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
   assert (act === exp) else begin
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      errors++;
   end
endtask

// One result line per test
task automatic finish_test(input string name, input int err_mark);
   if (errors == err_mark) begin
      tests_pass++;
      $display("%s: pass", name);
   end else begin
      tests_fail++;
      $display("%s: fail, %0d errors", name, errors - err_mark);
   end
endtask

//////////////////////////////////////////////////
// Host side of the serial line
//////////////////////////////////////////////////

// Inputs change just after the rising edge
task automatic drive_slot();
   @(posedge ftdi_clk);
   #1;
endtask

// Start, 8 data bits LSB first, stop
task automatic send_frame(input logic [7:0] b);
   logic [9:0] bits;
   bits = {1'b1, b, 1'b0};
   for (int i = 0; i < 10; i++) begin
      drive_slot();
      rx_i = bits[i];
      repeat (clks_per_bit - 1) @(posedge ftdi_clk);
   end
endtask

// Decodes tx_o on falling edges, returns at the stop bit centre
task automatic receive_frame(input logic expect_frame, output logic [7:0] data,
                             output logic got);
   int   waited;
   logic stop_bit;
   waited = 0;
   data   = '0;
   @(negedge ftdi_clk);
   // Silence window of 40 bit periods
   while (tx_o && waited < 40 * clks_per_bit) begin
      @(negedge ftdi_clk);
      waited++;
   end
   got = !tx_o;
   if (got) begin
      // Centre of the start bit
      repeat (clks_per_bit / 2) @(negedge ftdi_clk);
      for (int i = 0; i < 8; i++) begin
         repeat (clks_per_bit) @(negedge ftdi_clk);
         data[i] = tx_o;
      end
      repeat (clks_per_bit) @(negedge ftdi_clk);
      stop_bit = tx_o;
      assert (stop_bit) else begin
         $display("Frame on tx_o ended with a low stop bit");
         errors++;
      end
   end
   assert (got || !expect_frame) else begin
      $display("No frame on tx_o within 40 bit periods of silence");
      errors++;
   end
   assert (!got || expect_frame) else begin
      $display("Frame 0x%0h on tx_o where no reply was due", data);
      errors++;
   end
endtask

// Reply can start before the header stop bit ends
task automatic exchange(input logic [7:0] hdr, input logic expect_frame,
                        output logic [7:0] data, output logic got);
   fork
      send_frame(hdr);
      receive_frame(expect_frame, data, got);
   join
endtask

task automatic write_reg(input usb_pkg::reg_addr_t addr, input logic [7:0] data);
   send_frame({2'b11, addr});
   send_frame(data);
   // Outputs settled by the end of the stop bit
   @(negedge ftdi_clk);
endtask

task automatic read_check(input string name, input usb_pkg::reg_addr_t addr,
                          input logic [7:0] exp);
   logic [7:0] data;
   logic       got;
   exchange({2'b10, addr}, 1'b1, data, got);
   if (got) begin
      check_value(name, exp, data);
   end
endtask

// File: tb_usb_interface.sv
`timescale 1ns/1ps

module tb_usb_interface;

   localparam int clks_per_bit = 16;
   // Frames per test where a silence window counts as four
   localparam int frames_total = 20 * 4 + 10 + 4 * 4 + 8 + 2 * 17 + 8;
   localparam int cycle_limit  = frames_total * 10 * clks_per_bit * 2;

   logic                        ftdi_clk;
   logic                        reset;
   logic                        rx_i;
   logic [7:0]                  status_i;
   logic                        fifo_empty_i;
   logic [7:0]                  fifo_data_i;
   logic [usb_pkg::freq_w-1:0]  extclk_frequency_i;
   logic [usb_pkg::phase_w-1:0] phase_i;
   logic                        phase_done_i;
   logic                        tx_o;
   logic [7:0]                  gain_o;
   usb_pkg::settings_s          ctrl_o;
   logic                        fifo_rd_en_o;
   logic [usb_pkg::phase_w-1:0] phase_o;
   logic                        phase_ld_o;

   int         errors     = 0;
   int         tests_pass = 0;
   int         tests_fail = 0;
   int         ld_pulses  = 0;
   int         cycles     = 0;
   logic [7:0] fifo_q[$];
   logic       pop_pending = 1'b0;

   `include "tb_host_tasks.svh"

   usb_interface #(.CLKS_PER_BIT(clks_per_bit)) dut_i (.*);

   initial begin
      ftdi_clk = 1'b0;
      forever #4 ftdi_clk = ~ftdi_clk;
   end

   //////////////////////////////////////////////////
   // FIFO model and load pulse counter
   //////////////////////////////////////////////////

   always @(negedge ftdi_clk) begin
      if (fifo_rd_en_o) pop_pending = 1'b1;
      if (!reset && phase_ld_o) ld_pulses++;
   end

   // Head entry appears the cycle after the pop
   always @(posedge ftdi_clk) begin
      #1;
      if (pop_pending && fifo_q.size() > 0) fifo_data_i = fifo_q.pop_front();
      pop_pending  = 1'b0;
      fifo_empty_i = (fifo_q.size() == 0);
   end

   // Run limit
   initial begin
      while (cycles < cycle_limit) begin
         @(posedge ftdi_clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, run did not finish", cycle_limit);
      $display("TEST FAILED");
      $finish;
   end

   initial begin : test_seq
      logic [15:0]        r;
      logic [7:0]         data;
      logic [7:0]         got_byte;
      logic               got;
      usb_pkg::reg_addr_t addr;
      logic               load;
      logic [31:0]        f0;
      logic [31:0]        fread;
      int                 mark;
      int                 n;
      int                 pulses_before;
      logic [7:0]         sent[$];
      reset              = 1'b1;
      rx_i               = 1'b1;
      status_i           = '0;
      fifo_empty_i       = 1'b1;
      fifo_data_i        = '0;
      extclk_frequency_i = '0;
      phase_i            = '0;
      phase_done_i       = 1'b0;
      repeat (16) @(posedge ftdi_clk);
      #1;
      reset = 1'b0;

      // Register write and read-back
      mark = errors;
      for (int i = 0; i < 20; i++) begin
         r    = next_random();
         data = r[7:0];
         case (r[15:8] % 3)
            0: addr = usb_pkg::echo_addr;
            1: addr = usb_pkg::gain_addr;
            default: addr = usb_pkg::settings_addr;
         endcase
         write_reg(addr, data);
         if (addr == usb_pkg::gain_addr) check_value("echo_readback gain_o", data, gain_o);
         if (addr == usb_pkg::settings_addr) begin
            check_value("echo_readback ctrl_o", data,
                        {ctrl_o.src_internal, ctrl_o.adc_clk_ext, ctrl_o.trig_wait,
                         ctrl_o.pll_reset, ctrl_o.arm, ctrl_o.trig_high,
                         ctrl_o.hilow, ctrl_o.sys_reset});
         end
         read_check("echo_readback read", addr, data);
      end
      finish_test("echo_readback", mark);

      // Status pass-through and two requests with no reply
      mark = errors;
      r    = next_random();
      drive_slot();
      status_i = r[7:0];
      read_check("status_ignored status", usb_pkg::status_addr, r[7:0]);
      r = next_random();
      exchange({1'b0, r[6:0]}, 1'b0, got_byte, got);
      r    = next_random();
      addr = 11 + r % 53;
      exchange({2'b10, addr}, 1'b0, got_byte, got);
      finish_test("status_ignored", mark);

      // Phase load through 9 and 10
      mark = errors;
      for (int i = 0; i < 4; i++) begin
         r    = next_random();
         // Last pass leaves the load bit clear
         load = (i != 3);
         write_reg(usb_pkg::phase_lo_addr, r[7:0]);
         pulses_before = ld_pulses;
         write_reg(usb_pkg::phase_hi_addr, {6'b0, load, r[8]});
         check_value("phase_load phase_o", r[8:0], phase_o);
         check_value("phase_load pulses", load, ld_pulses - pulses_before);
      end
      finish_test("phase_load", mark);

      // Capture on done and clear by a load
      mark = errors;
      r    = next_random();
      drive_slot();
      phase_i      = r[8:0];
      phase_done_i = 1'b1;
      drive_slot();
      phase_done_i = 1'b0;
      // Input moves on once done drops
      phase_i      = ~r[8:0];
      read_check("phase_capture low", usb_pkg::phase_lo_addr, r[7:0]);
      read_check("phase_capture high", usb_pkg::phase_hi_addr, {6'b0, 1'b1, r[8]});
      write_reg(usb_pkg::phase_hi_addr, 8'h02);
      read_check("phase_capture cleared", usb_pkg::phase_hi_addr, 8'h00);
      finish_test("phase_capture", mark);

      // FIFO dump followed by silence
      mark = errors;
      for (int k = 0; k < 2; k++) begin
         r = next_random();
         n = 1 + r % 12;
         sent.delete();
         drive_slot();
         for (int j = 0; j < n; j++) begin
            r = next_random();
            sent.push_back(r[7:0]);
            fifo_q.push_back(r[7:0]);
         end
         exchange({2'b10, usb_pkg::adcdata_addr}, 1'b1, got_byte, got);
         for (int j = 0; j < n; j++) begin
            if (j > 0) receive_frame(1'b1, got_byte, got);
            if (got) check_value("adc_dump byte", sent[j], got_byte);
         end
         receive_frame(1'b0, got_byte, got);
      end
      finish_test("adc_dump", mark);

      // Snapshot holds across four reads
      mark = errors;
      f0   = {next_random(), next_random()};
      drive_slot();
      extclk_frequency_i = f0;
      fread = '0;
      for (int j = 0; j < 4; j++) begin
         addr = usb_pkg::extfreq_addr0 + j;
         exchange({2'b10, addr}, 1'b1, got_byte, got);
         fread[8*j +: 8] = got_byte;
         drive_slot();
         extclk_frequency_i = {next_random(), next_random()};
      end
      check_value("freq_snapshot value", f0, fread);
      finish_test("freq_snapshot", mark);

      $display("Summary: %0d passing tests, %0d failing tests, %0d errors",
               tests_pass, tests_fail, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+.
usb_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_sequencer.sv
config_regs.sv
usb_interface.sv
tb_usb_interface.sv
